// ==== verilog/eth_pkg.sv ====
// Ethernet framing package with address map, register offsets, frame constants and CRC-32 step
package eth_pkg;

   localparam int BUF_AW = 11;                          // Byte address width, 2048 bytes

   localparam logic [47:0] MAC_RESET = 48'h2301_0089_0702;

   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;

   localparam int MIN_FRAME = 60;                       // Without FCS
   localparam int IFG_BYTES = 12;

   localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320; // Reflected polynomial
   localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B; // Good frame, MSB-first bit order

   // Bus address bits 12:11
   localparam logic [1:0] REGION_RXBUF = 2'd0;
   localparam logic [1:0] REGION_REGS  = 2'd1;
   localparam logic [1:0] REGION_TXBUF = 2'd2;

   // Word offsets, bus address bits 5:2
   localparam logic [3:0] REG_MAC_LO  = 4'd0;
   localparam logic [3:0] REG_CTRL    = 4'd1;
   localparam logic [3:0] REG_TX      = 4'd2;
   localparam logic [3:0] REG_RX_STAT = 4'd6;
   localparam logic [3:0] REG_RX_LEN  = 4'd7;

   // One byte through the CRC register, LSB first
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         if (c[0] ^ data[i])
            c = (c >> 1) ^ CRC_POLY;
         else
            c = c >> 1;
      end
      return c;
   endfunction

endpackage

// ==== verilog/frame_buffer.sv ====
// Dual-port frame memory with a byte port and a 32-bit word port
`timescale 1ns/1ps

module frame_buffer
   import eth_pkg::*;
(
   input  logic              i_clk_rmii,
   input  logic              i_byte_we,
   input  logic [BUF_AW-1:0] i_byte_addr,
   input  logic [7:0]        i_byte_wdata,
   output logic [7:0]        o_byte_rdata,
   input  logic              i_word_en,
   input  logic              i_word_we,
   input  logic [BUF_AW-3:0] i_word_addr,
   input  logic [31:0]       i_word_wdata,
   output logic [31:0]       o_word_rdata
);

   logic [31:0] mem [2**(BUF_AW-2)];                    // Byte n in word n/4, lane n%4

   always_ff @(posedge i_clk_rmii)
   begin
      if (i_byte_we)
         mem[i_byte_addr[BUF_AW-1:2]][{i_byte_addr[1:0], 3'b000} +: 8] <= i_byte_wdata;
      o_byte_rdata <= mem[i_byte_addr[BUF_AW-1:2]][{i_byte_addr[1:0], 3'b000} +: 8];
      if (i_word_en)
      begin
         if (i_word_we)
            mem[i_word_addr] <= i_word_wdata;
         o_word_rdata <= mem[i_word_addr];
      end
   end

   a_byte_addr_known: assert property (@(posedge i_clk_rmii)
      i_byte_we |-> !$isunknown(i_byte_addr));

endmodule

// ==== verilog/rmii_rx.sv ====
// RMII receive deserializer with preamble and SFD alignment and loopback select
`timescale 1ns/1ps

module rmii_rx
   import eth_pkg::*;
(
   input  logic       i_clk_rmii,
   input  logic       i_rstn,
   input  logic [1:0] i_rxd,
   input  logic       i_crs_dv,
   input  logic       i_loopback,
   input  logic [1:0] i_txd,
   input  logic       i_tx_en,
   output logic [7:0] o_rx_byte,
   output logic       o_rx_byte_stb,
   output logic       o_rx_frame_end
);

   logic [1:0]  rxd_q;
   logic        dv_q;
   logic [15:0] window;                                 // Newest dibit at the top
   logic [15:0] win_nxt;
   logic        in_frame;
   logic [1:0]  dibit_cnt;

   assign win_nxt = {rxd_q, window[15:2]};

   always_ff @(posedge i_clk_rmii)
   begin
      rxd_q <= i_loopback ? i_txd : i_rxd;              // PHY pins or own transmitter
      if (in_frame && dv_q && dibit_cnt == 2'd3)
         o_rx_byte <= win_nxt[15:8];
   end

   always_ff @(posedge i_clk_rmii)
   begin
      if (!i_rstn)
      begin
         dv_q           <= 1'b0;
         window         <= '0;
         in_frame       <= 1'b0;
         dibit_cnt      <= '0;
         o_rx_byte_stb  <= 1'b0;
         o_rx_frame_end <= 1'b0;
      end
      else
      begin
         dv_q           <= i_loopback ? i_tx_en : i_crs_dv;
         o_rx_byte_stb  <= 1'b0;
         o_rx_frame_end <= 1'b0;
         if (!dv_q)
         begin
            window         <= '0;
            dibit_cnt      <= '0;
            in_frame       <= 1'b0;
            o_rx_frame_end <= in_frame;                 // Carrier gone
         end
         else
         begin
            window <= win_nxt;
            if (!in_frame)
            begin
               if (win_nxt == {SFD_BYTE, PREAMBLE_BYTE})
                  in_frame <= 1'b1;
               dibit_cnt <= '0;
            end
            else
            begin
               dibit_cnt <= dibit_cnt + 2'd1;
               if (dibit_cnt == 2'd3)
                  o_rx_byte_stb <= 1'b1;
            end
         end
      end
   end

   // Bytes cannot arrive faster than four dibits apart
   a_stb_spacing: assert property (@(posedge i_clk_rmii) disable iff (!i_rstn)
      o_rx_byte_stb |=> !o_rx_byte_stb [*3]);

endmodule

// ==== verilog/eth_rx_mac.sv ====
// Receive framing with byte count, destination filter, FCS check and buffer writes
`timescale 1ns/1ps

module eth_rx_mac
   import eth_pkg::*;
(
   input  logic              i_clk_rmii,
   input  logic              i_rstn,
   input  logic [7:0]        i_rx_byte,
   input  logic              i_rx_byte_stb,
   input  logic              i_rx_frame_end,
   input  logic [47:0]       i_mac_addr,
   input  logic              i_promiscuous,
   input  logic              i_rx_clear,
   output logic              o_buf_we,
   output logic [BUF_AW-1:0] o_buf_addr,
   output logic [7:0]        o_buf_wdata,
   output logic              o_rx_ready,
   output logic [BUF_AW-1:0] o_rx_length,
   output logic              o_rx_bad_fcs
);

   logic [BUF_AW-1:0] byte_cnt;
   logic [47:0]       dest;                             // First byte in bits 47:40
   logic [31:0]       crc;
   logic [31:0]       crc_rev;
   logic              hold;                             // Frame started while buffer full
   logic              take;
   logic              addr_ok;

   assign take    = i_rx_byte_stb && !o_rx_ready && !hold;
   assign crc_rev = {<<{crc}};
   assign addr_ok = (dest == i_mac_addr) || (&dest) || (dest[47:24] == 24'h01005E)
                    || i_promiscuous;

   assign o_buf_we    = take;
   assign o_buf_addr  = byte_cnt;
   assign o_buf_wdata = i_rx_byte;

   always_ff @(posedge i_clk_rmii)
   begin
      if (take && byte_cnt < 6)
         dest <= {dest[39:0], i_rx_byte};
   end

   always_ff @(posedge i_clk_rmii)
   begin
      if (!i_rstn)
      begin
         byte_cnt     <= '0;
         crc          <= '1;
         hold         <= 1'b0;
         o_rx_ready   <= 1'b0;
         o_rx_length  <= '0;
         o_rx_bad_fcs <= 1'b0;
      end
      else
      begin
         if (i_rx_clear)
         begin
            o_rx_ready   <= 1'b0;
            o_rx_length  <= '0;
            o_rx_bad_fcs <= 1'b0;
         end
         if (i_rx_byte_stb && (o_rx_ready || hold))
            hold <= 1'b1;                               // Drop the rest of this frame
         if (take)
         begin
            byte_cnt <= byte_cnt + 1'b1;
            crc      <= crc32_byte(crc, i_rx_byte);     // Runs over the FCS too
         end
         if (i_rx_frame_end)
         begin
            byte_cnt <= '0;
            crc      <= '1;
            hold     <= 1'b0;
            if (!hold && !o_rx_ready && byte_cnt > 6 && addr_ok)
            begin
               o_rx_ready   <= 1'b1;
               o_rx_length  <= byte_cnt;
               o_rx_bad_fcs <= (crc_rev != CRC_RESIDUE);
            end
         end
      end
   end

endmodule

// ==== verilog/eth_tx_mac.sv ====
// Transmit framing with preamble, payload, padding, FCS, gap and dibit output
`timescale 1ns/1ps

module eth_tx_mac
   import eth_pkg::*;
(
   input  logic              i_clk_rmii,
   input  logic              i_rstn,
   input  logic              i_tx_start,
   input  logic [BUF_AW-1:0] i_tx_length,
   output logic [BUF_AW-1:0] o_buf_addr,
   input  logic [7:0]        i_buf_rdata,
   output logic [1:0]        o_txd,
   output logic              o_tx_en,
   output logic              o_tx_busy
);

   typedef enum logic [2:0] {S_PRE, S_PAY, S_PAD, S_FCS, S_GAP} tx_state_t;

   tx_state_t         state;                            // Kind of the next byte to load
   logic [BUF_AW-1:0] cnt;
   logic [BUF_AW-1:0] len;
   logic [BUF_AW-1:0] addr;
   logic [1:0]        ph;                               // Dibit within the current byte
   logic [7:0]        sh;
   logic [7:0]        byte_val;
   logic [31:0]       crc;
   logic [31:0]       fcs;
   logic              start;
   logic              step;
   logic              load;

   assign start      = i_tx_start && !o_tx_busy;
   assign step       = o_tx_busy && ph == 2'd3;
   assign load       = start || (step && state != S_GAP);
   assign fcs        = ~crc;
   assign o_buf_addr = addr;

   always_comb
   begin
      case (state)
         S_PRE:   byte_val = (cnt == 7) ? SFD_BYTE : PREAMBLE_BYTE;
         S_PAY:   byte_val = i_buf_rdata;                // Address set four cycles earlier
         S_FCS:   byte_val = fcs[{cnt[1:0], 3'b000} +: 8];
         default: byte_val = 8'h00;                      // Pad
      endcase
   end

   always_ff @(posedge i_clk_rmii)
   begin
      if (start)
      begin
         len  <= i_tx_length;
         addr <= '0;
         crc  <= '1;
      end
      if (load)
         sh <= {2'b00, byte_val[7:2]};
      else
         sh <= {2'b00, sh[7:2]};
      if (load && (state == S_PAY || state == S_PAD))
         crc <= crc32_byte(crc, byte_val);
      if (load && state == S_PAY)
         addr <= addr + 1'b1;
   end

   always_ff @(posedge i_clk_rmii)
   begin
      if (!i_rstn)
      begin
         state     <= S_PRE;
         cnt       <= '0;
         ph        <= '0;
         o_txd     <= '0;
         o_tx_en   <= 1'b0;
         o_tx_busy <= 1'b0;
      end
      else
      begin
         if (o_tx_busy)
            ph <= ph + 2'd1;
         if (start)
         begin
            ph        <= '0;
            o_tx_en   <= 1'b1;
            o_tx_busy <= 1'b1;
         end

         if (load)
            o_txd <= byte_val[1:0];
         else if (step && state == S_GAP)
            o_txd <= 2'b00;
         else if (o_tx_en)
            o_txd <= sh[1:0];

         if (load)
         begin
            case (state)
               S_PRE:
               begin
                  cnt <= (cnt == 7) ? '0 : cnt + 1'b1;
                  if (cnt == 7)
                     state <= (len == 0) ? S_PAD : S_PAY;
               end
               S_PAY:
               begin
                  cnt <= cnt + 1'b1;
                  if (cnt == len - 1'b1 && cnt >= MIN_FRAME - 1)
                  begin
                     state <= S_FCS;
                     cnt   <= '0;
                  end
                  else if (cnt == len - 1'b1)
                     state <= S_PAD;                    // Pad count continues from here
               end
               S_PAD:
               begin
                  cnt <= (cnt == MIN_FRAME - 1) ? '0 : cnt + 1'b1;
                  if (cnt == MIN_FRAME - 1)
                     state <= S_FCS;
               end
               default:
               begin
                  cnt <= (cnt == 3) ? '0 : cnt + 1'b1;
                  if (cnt == 3)
                     state <= S_GAP;
               end
            endcase
         end
         else if (step && state == S_GAP)
         begin
            o_tx_en <= 1'b0;                            // First gap step ends the frame
            cnt     <= cnt + 1'b1;
            if (cnt == IFG_BYTES)
            begin
               o_tx_busy <= 1'b0;
               state     <= S_PRE;
               cnt       <= '0;
            end
         end
      end
   end

   a_en_in_busy: assert property (@(posedge i_clk_rmii) disable iff (!i_rstn)
      o_tx_en |-> o_tx_busy);

endmodule

// ==== verilog/eth_regs.sv ====
// Register block with bus decode, control and status registers, read mux and interrupt
`timescale 1ns/1ps

module eth_regs
   import eth_pkg::*;
(
   input  logic              i_clk_rmii,
   input  logic              i_rstn,
   input  logic              i_bus_sel,
   input  logic              i_bus_we,
   input  logic [12:0]       i_bus_addr,
   input  logic [31:0]       i_bus_wdata,
   output logic [31:0]       o_bus_rdata,
   output logic              o_rxbuf_en,
   output logic              o_txbuf_en,
   output logic              o_txbuf_we,
   output logic [47:0]       o_mac_addr,
   output logic              o_promiscuous,
   output logic              o_loopback,
   output logic              o_tx_start,
   output logic [BUF_AW-1:0] o_tx_length,
   output logic              o_rx_clear,
   input  logic [31:0]       i_rxbuf_rdata,
   input  logic [31:0]       i_txbuf_rdata,
   input  logic              i_rx_ready,
   input  logic [BUF_AW-1:0] i_rx_length,
   input  logic              i_rx_bad_fcs,
   input  logic              i_tx_busy,
   output logic              o_irq
);

   logic [1:0]  region;
   logic [3:0]  offset;
   logic        reg_wr;
   logic        irq_en;
   logic        rd_q;
   logic [1:0]  rd_region_q;
   logic [3:0]  rd_off_q;
   logic [31:0] reg_rdata;

   assign region = i_bus_addr[12:11];
   assign offset = i_bus_addr[5:2];
   assign reg_wr = i_bus_sel && i_bus_we && region == REGION_REGS;

   assign o_rxbuf_en = i_bus_sel && region == REGION_RXBUF;
   assign o_txbuf_en = i_bus_sel && region == REGION_TXBUF;
   assign o_txbuf_we = o_txbuf_en && i_bus_we;

   always_ff @(posedge i_clk_rmii)
   begin
      if (!i_rstn)
      begin
         o_mac_addr    <= MAC_RESET;
         irq_en        <= 1'b0;
         o_promiscuous <= 1'b0;
         o_loopback    <= 1'b0;
         o_tx_length   <= '0;
         o_tx_start    <= 1'b0;
         o_rx_clear    <= 1'b0;
         o_irq         <= 1'b0;
         rd_q          <= 1'b0;
      end
      else
      begin
         o_tx_start <= reg_wr && offset == REG_TX;
         o_rx_clear <= reg_wr && offset == REG_RX_STAT;
         o_irq      <= i_rx_ready && irq_en;
         rd_q       <= i_bus_sel && !i_bus_we;
         if (reg_wr && offset == REG_MAC_LO)
            o_mac_addr[31:0] <= i_bus_wdata;
         if (reg_wr && offset == REG_CTRL)
         begin
            irq_en            <= i_bus_wdata[31];
            o_promiscuous     <= i_bus_wdata[30];
            o_loopback        <= i_bus_wdata[26];
            o_mac_addr[47:32] <= i_bus_wdata[15:0];
         end
         if (reg_wr && offset == REG_TX)
            o_tx_length <= i_bus_wdata[BUF_AW-1:0];
      end
   end

   // Where the read went, for the cycle its data returns
   always_ff @(posedge i_clk_rmii)
   begin
      rd_region_q <= region;
      rd_off_q    <= offset;
   end

   always_comb
   begin
      case (rd_off_q)
         REG_MAC_LO:  reg_rdata = o_mac_addr[31:0];
         REG_CTRL:    reg_rdata = {irq_en, o_promiscuous, 3'b000, o_loopback, 10'd0,
                                   o_mac_addr[47:32]};
         REG_TX:      reg_rdata = {i_tx_busy, 20'd0, o_tx_length};
         REG_RX_STAT: reg_rdata = {30'd0, o_irq, i_rx_ready};
         REG_RX_LEN:  reg_rdata = {i_rx_bad_fcs, 20'd0, i_rx_length};
         default:     reg_rdata = '0;
      endcase
   end

   always_comb
   begin
      o_bus_rdata = '0;
      if (rd_q)
      begin
         case (rd_region_q)
            REGION_RXBUF: o_bus_rdata = i_rxbuf_rdata;
            REGION_REGS:  o_bus_rdata = reg_rdata;
            REGION_TXBUF: o_bus_rdata = i_txbuf_rdata;
            default:      o_bus_rdata = '0;
         endcase
      end
   end

endmodule

// ==== verilog/framing_top.sv ====
// Top level of the RMII framing block with buffers, receive and transmit MACs and registers
`timescale 1ns/1ps

module framing_top
   import eth_pkg::*;
(
   input  logic        clk_rmii,
   input  logic        rstn,
   input  logic        i_bus_sel,
   input  logic        i_bus_we,
   input  logic [12:0] i_bus_addr,
   input  logic [31:0] i_bus_wdata,
   output logic [31:0] o_bus_rdata,
   input  logic [1:0]  i_rxd,
   input  logic        i_crs_dv,
   output logic [1:0]  o_txd,
   output logic        o_tx_en,
   output logic        o_irq
);

   logic [47:0]       mac_addr;
   logic              promiscuous;
   logic              loopback;
   logic              tx_start;
   logic [BUF_AW-1:0] tx_length;
   logic              tx_busy;
   logic              rx_clear;
   logic              rx_ready;
   logic [BUF_AW-1:0] rx_length;
   logic              rx_bad_fcs;
   logic              rxbuf_en;
   logic              txbuf_en;
   logic              txbuf_we;
   logic [31:0]       rxbuf_rdata;
   logic [31:0]       txbuf_rdata;
   logic [7:0]        rx_byte;
   logic              rx_byte_stb;
   logic              rx_frame_end;
   logic              rxbuf_we;
   logic [BUF_AW-1:0] rxbuf_addr;
   logic [7:0]        rxbuf_wdata;
   logic [BUF_AW-1:0] txbuf_addr;
   logic [7:0]        txbuf_byte;

   eth_regs regs_i (
      .i_clk_rmii    (clk_rmii),
      .i_rstn        (rstn),
      .i_bus_sel     (i_bus_sel),
      .i_bus_we      (i_bus_we),
      .i_bus_addr    (i_bus_addr),
      .i_bus_wdata   (i_bus_wdata),
      .o_bus_rdata   (o_bus_rdata),
      .o_rxbuf_en    (rxbuf_en),
      .o_txbuf_en    (txbuf_en),
      .o_txbuf_we    (txbuf_we),
      .o_mac_addr    (mac_addr),
      .o_promiscuous (promiscuous),
      .o_loopback    (loopback),
      .o_tx_start    (tx_start),
      .o_tx_length   (tx_length),
      .o_rx_clear    (rx_clear),
      .i_rxbuf_rdata (rxbuf_rdata),
      .i_txbuf_rdata (txbuf_rdata),
      .i_rx_ready    (rx_ready),
      .i_rx_length   (rx_length),
      .i_rx_bad_fcs  (rx_bad_fcs),
      .i_tx_busy     (tx_busy),
      .o_irq         (o_irq)
   );

   rmii_rx rmii_rx_i (
      .i_clk_rmii     (clk_rmii),
      .i_rstn         (rstn),
      .i_rxd          (i_rxd),
      .i_crs_dv       (i_crs_dv),
      .i_loopback     (loopback),
      .i_txd          (o_txd),
      .i_tx_en        (o_tx_en),
      .o_rx_byte      (rx_byte),
      .o_rx_byte_stb  (rx_byte_stb),
      .o_rx_frame_end (rx_frame_end)
   );

   eth_rx_mac rx_mac_i (
      .i_clk_rmii     (clk_rmii),
      .i_rstn         (rstn),
      .i_rx_byte      (rx_byte),
      .i_rx_byte_stb  (rx_byte_stb),
      .i_rx_frame_end (rx_frame_end),
      .i_mac_addr     (mac_addr),
      .i_promiscuous  (promiscuous),
      .i_rx_clear     (rx_clear),
      .o_buf_we       (rxbuf_we),
      .o_buf_addr     (rxbuf_addr),
      .o_buf_wdata    (rxbuf_wdata),
      .o_rx_ready     (rx_ready),
      .o_rx_length    (rx_length),
      .o_rx_bad_fcs   (rx_bad_fcs)
   );

   eth_tx_mac tx_mac_i (
      .i_clk_rmii  (clk_rmii),
      .i_rstn      (rstn),
      .i_tx_start  (tx_start),
      .i_tx_length (tx_length),
      .o_buf_addr  (txbuf_addr),
      .i_buf_rdata (txbuf_byte),
      .o_txd       (o_txd),
      .o_tx_en     (o_tx_en),
      .o_tx_busy   (tx_busy)
   );

   // CPU reads this one by words, the receive MAC fills it by bytes
   frame_buffer rx_buf_i (
      .i_clk_rmii   (clk_rmii),
      .i_byte_we    (rxbuf_we),
      .i_byte_addr  (rxbuf_addr),
      .i_byte_wdata (rxbuf_wdata),
      .o_byte_rdata (),
      .i_word_en    (rxbuf_en),
      .i_word_we    (1'b0),
      .i_word_addr  (i_bus_addr[BUF_AW-1:2]),
      .i_word_wdata (i_bus_wdata),
      .o_word_rdata (rxbuf_rdata)
   );

   frame_buffer tx_buf_i (
      .i_clk_rmii   (clk_rmii),
      .i_byte_we    (1'b0),
      .i_byte_addr  (txbuf_addr),
      .i_byte_wdata (8'h00),
      .o_byte_rdata (txbuf_byte),
      .i_word_en    (txbuf_en),
      .i_word_we    (txbuf_we),
      .i_word_addr  (i_bus_addr[BUF_AW-1:2]),
      .i_word_wdata (i_bus_wdata),
      .o_word_rdata (txbuf_rdata)
   );

endmodule

// ==== verif/tb_framing_top.sv ====
// Directed testbench for framing_top with bus, RMII and transmit capture tasks and a reference CRC
`timescale 1ns/1ps

module tb_framing_top
   import eth_pkg::*;
();

   // Byte times of all frames: two transmits, seven receives, one loopback counted twice
   localparam int FRAME_BYTES  = (84 + 124) + 7 * (8 + 84 + 4) + 2 * 84;
   localparam int LIMIT_CYCLES = 4 * FRAME_BYTES + 4000;

   logic        clk_rmii;
   logic        rstn;
   logic        bus_sel;
   logic        bus_we;
   logic [12:0] bus_addr;
   logic [31:0] bus_wdata;
   logic [31:0] bus_rdata;
   logic [1:0]  rxd;
   logic        crs_dv;
   logic [1:0]  txd;
   logic        tx_en;
   logic        irq;

   int          errors;
   integer      seed;
   logic [7:0]  pkt[$];                                 // Frame bytes after the SFD
   logic [7:0]  cap[$];                                 // Bytes rebuilt from o_txd

   framing_top framing_top_i (
      .clk_rmii    (clk_rmii),
      .rstn        (rstn),
      .i_bus_sel   (bus_sel),
      .i_bus_we    (bus_we),
      .i_bus_addr  (bus_addr),
      .i_bus_wdata (bus_wdata),
      .o_bus_rdata (bus_rdata),
      .i_rxd       (rxd),
      .i_crs_dv    (crs_dv),
      .o_txd       (txd),
      .o_tx_en     (tx_en),
      .o_irq       (irq)
   );

   initial
   begin
      clk_rmii = 1'b0;
      forever #5 clk_rmii = ~clk_rmii;
   end

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_event(input logic ok, input string what);
      assert (ok)
      else
      begin
         errors++;
         $display("ERROR at %0t: %s", $time, what);
      end
   endtask

   function automatic logic [12:0] reg_addr(input logic [3:0] off);
      return {REGION_REGS, 5'd0, off, 2'b00};
   endfunction

   task automatic bus_write(input logic [12:0] addr, input logic [31:0] data);
      @(posedge clk_rmii);
      bus_sel   <= 1'b1;
      bus_we    <= 1'b1;
      bus_addr  <= addr;
      bus_wdata <= data;
      @(posedge clk_rmii);
      bus_sel   <= 1'b0;
      bus_we    <= 1'b0;
   endtask

   task automatic bus_read(input logic [12:0] addr, output logic [31:0] data);
      @(posedge clk_rmii);
      bus_sel  <= 1'b1;
      bus_we   <= 1'b0;
      bus_addr <= addr;
      @(posedge clk_rmii);
      bus_sel  <= 1'b0;
      @(negedge clk_rmii);                              // Read data valid one cycle later
      data = bus_rdata;
   endtask

   // Reference FCS register, whole byte folded in before the eight shifts
   function automatic logic [31:0] frame_crc(input int n);
      logic [31:0] c;
      int          i;
      int          k;
      c = 32'hFFFF_FFFF;
      for (i = 0; i < n; i++)
      begin
         c = c ^ {24'd0, pkt[i]};
         for (k = 0; k < 8; k++)
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
      return c;
   endfunction

   task automatic append_fcs();
      logic [31:0] fcs;
      int          i;
      fcs = ~frame_crc(pkt.size());
      for (i = 0; i < 4; i++)
         pkt.push_back(fcs[8*i +: 8]);                  // Low byte first on the wire
   endtask

   task automatic make_frame(input logic [47:0] dest, input int n);
      int i;
      pkt.delete();
      for (i = 0; i < 6; i++)
         pkt.push_back(dest[47-8*i -: 8]);
      for (i = 0; i < 6; i++)
         pkt.push_back(8'h10 + 8'(i));                  // Source address
      while (pkt.size() < n)
         pkt.push_back(8'($random(seed)));
   endtask

   task automatic send_rmii_frame();
      logic [7:0] b;
      int         i;
      int         d;
      for (i = 0; i < 8 + pkt.size(); i++)
      begin
         b = (i < 7) ? 8'h55 : (i == 7) ? 8'hD5 : pkt[i-8];
         for (d = 0; d < 4; d++)
         begin
            @(posedge clk_rmii);
            crs_dv <= 1'b1;
            rxd    <= b[2*d +: 2];
         end
      end
      @(posedge clk_rmii);
      crs_dv <= 1'b0;
      rxd    <= 2'b00;
      repeat (16) @(posedge clk_rmii);
   endtask

   task automatic capture_tx_frame(output int start_wait, output int en_cycles);
      logic [7:0] b;
      int         n;
      int         wait_cnt;
      int         en_cnt;
      cap.delete();
      b        = '0;
      n        = 0;
      wait_cnt = 0;
      en_cnt   = 0;
      while (!tx_en && wait_cnt < 64)
      begin
         @(negedge clk_rmii);
         wait_cnt++;
      end
      check_event(tx_en, "o_tx_en never rose after the transmit start");
      while (tx_en)
      begin
         b = {txd, b[7:2]};                             // LSB dibit arrives first
         en_cnt++;
         n++;
         if (n == 4)
         begin
            cap.push_back(b);
            n = 0;
         end
         @(negedge clk_rmii);
      end
      start_wait = wait_cnt;
      en_cycles  = en_cnt;
   endtask

   task automatic load_tx_buffer(input int n);
      logic [31:0] word;
      int          w;
      int          b;
      for (w = 0; w < (n + 3) / 4; w++)
      begin
         word = '0;
         for (b = 0; b < 4; b++)
            if (4 * w + b < n)
               word[8*b +: 8] = pkt[4*w + b];
         bus_write({REGION_TXBUF, w[8:0], 2'b00}, word);
      end
   endtask

   task automatic wait_rx_ready(input int max_reads, output logic seen);
      logic [31:0] rd;
      int          n;
      seen = 1'b0;
      for (n = 0; n < max_reads && !seen; n++)
      begin
         bus_read(reg_addr(REG_RX_STAT), rd);
         seen = rd[0];
      end
   endtask

   task automatic wait_tx_idle();
      logic [31:0] rd;
      int          n;
      rd = 32'h8000_0000;
      for (n = 0; n < 200 && rd[31]; n++)
         bus_read(reg_addr(REG_TX), rd);
      check_event(!rd[31], "tx_busy did not fall after the inter-frame gap");
   endtask

   task automatic check_rx_status(input int exp_len, input logic exp_bad);
      logic [31:0] rd;
      bus_read(reg_addr(REG_RX_LEN), rd);
      check_value("rx_length", 32'(rd[10:0]), 32'(exp_len));
      check_value("rx_bad_fcs", 32'(rd[31]), 32'(exp_bad));
   endtask

   task automatic check_rx_buffer();
      logic [31:0] rd;
      int          w;
      int          b;
      for (w = 0; w < (pkt.size() + 3) / 4; w++)
      begin
         bus_read({REGION_RXBUF, w[8:0], 2'b00}, rd);
         for (b = 0; b < 4; b++)
            if (4 * w + b < pkt.size())
               check_value("rx buffer byte", 32'(rd[8*b +: 8]), 32'(pkt[4*w + b]));
      end
   endtask

   task automatic clear_rx();
      bus_write(reg_addr(REG_RX_STAT), 32'd0);
      repeat (3) @(posedge clk_rmii);                   // Clear pulse, then status, then irq
      @(negedge clk_rmii);
   endtask

   task automatic receive_frame(input logic [47:0] dest, input logic expect_ok, input string what);
      logic seen;
      make_frame(dest, 60);
      append_fcs();
      send_rmii_frame();
      wait_rx_ready(10, seen);
      check_event(seen == expect_ok, what);
      if (seen)
      begin
         check_rx_status(pkt.size(), 1'b0);
         clear_rx();
      end
   endtask

   task automatic test_registers();
      logic [31:0] rd;
      check_value("o_irq", 32'(irq), 32'd0);
      check_value("o_tx_en", 32'(tx_en), 32'd0);
      bus_read(reg_addr(REG_MAC_LO), rd);
      check_value("mac_lo", rd, MAC_RESET[31:0]);
      bus_read(reg_addr(REG_CTRL), rd);
      check_value("ctrl", rd, {16'd0, MAC_RESET[47:32]});
      bus_write(reg_addr(REG_MAC_LO), 32'hA5C3_1E77);
      bus_write(reg_addr(REG_CTRL), 32'h4400_BEEF);
      bus_read(reg_addr(REG_MAC_LO), rd);
      check_value("mac_lo", rd, 32'hA5C3_1E77);
      bus_read(reg_addr(REG_CTRL), rd);
      check_value("ctrl", rd, 32'h4400_BEEF);
      bus_read(reg_addr(4'd3), rd);                     // Undefined register
      check_value("undefined register", rd, 32'd0);
      bus_read(13'h1800, rd);                           // Region 3
      check_value("region 3", rd, 32'd0);
      bus_write(reg_addr(REG_MAC_LO), MAC_RESET[31:0]);
      bus_write(reg_addr(REG_CTRL), {16'd0, MAC_RESET[47:32]});
   endtask

   task automatic test_transmit(input int len);
      logic [31:0] rd_busy;
      int          start_wait;
      int          en_cycles;
      int          i;
      pkt.delete();
      for (i = 0; i < len; i++)
         pkt.push_back(8'($random(seed)));
      load_tx_buffer(len);
      while (pkt.size() < 60)
         pkt.push_back(8'h00);                          // Padding to minimum size
      append_fcs();
      bus_write(reg_addr(REG_TX), 32'(len));
      fork
         capture_tx_frame(start_wait, en_cycles);
         begin
            repeat (40) @(posedge clk_rmii);
            bus_read(reg_addr(REG_TX), rd_busy);
         end
      join
      check_value("tx_en start delay", 32'(start_wait), 32'd2);
      check_value("tx_en cycles", 32'(en_cycles), 32'(4 * (8 + pkt.size())));
      check_value("tx_busy in frame", 32'(rd_busy[31]), 32'd1);
      check_value("tx_length", 32'(rd_busy[10:0]), 32'(len));
      check_value("tx byte count", 32'(cap.size()), 32'(8 + pkt.size()));
      for (i = 0; i < cap.size() && i < 8 + pkt.size(); i++)
         check_value("tx byte", 32'(cap[i]),
                     (i < 7) ? 32'h55 : (i == 7) ? 32'hD5 : 32'(pkt[i-8]));
      wait_tx_idle();
   endtask

   task automatic test_unicast_receive();
      logic [31:0] rd;
      logic        seen;
      bus_write(reg_addr(REG_CTRL), {1'b1, 15'd0, MAC_RESET[47:32]});
      make_frame(MAC_RESET, 61);
      append_fcs();
      send_rmii_frame();
      wait_rx_ready(10, seen);
      check_event(seen, "rx_ready did not rise for a good unicast frame");
      check_rx_status(pkt.size(), 1'b0);
      check_rx_buffer();
      repeat (2) @(negedge clk_rmii);
      check_value("o_irq", 32'(irq), 32'd1);
      bus_read(reg_addr(REG_RX_STAT), rd);
      check_value("rx_stat with irq", rd, 32'd3);       // Irq in bit 1, ready in bit 0
      clear_rx();
      check_value("o_irq after clear", 32'(irq), 32'd0);
      bus_write(reg_addr(REG_CTRL), {16'd0, MAC_RESET[47:32]});
   endtask

   task automatic test_address_filter();
      receive_frame(48'h02AA_BBCC_DDEE, 1'b0, "foreign unicast frame was accepted");
      receive_frame(48'hFFFF_FFFF_FFFF, 1'b1, "broadcast frame was dropped");
      receive_frame(48'h0100_5E7F_0001, 1'b1, "IPv4 multicast frame was dropped");
      bus_write(reg_addr(REG_CTRL), {2'b01, 14'd0, MAC_RESET[47:32]});
      receive_frame(48'h02AA_BBCC_DDEE, 1'b1, "foreign frame dropped in promiscuous mode");
      bus_write(reg_addr(REG_CTRL), {16'd0, MAC_RESET[47:32]});
   endtask

   task automatic test_bad_fcs_hold();
      logic [31:0] rd;
      logic        seen;
      make_frame(MAC_RESET, 60);
      append_fcs();
      pkt[61] = pkt[61] ^ 8'h5A;                        // Second FCS byte
      send_rmii_frame();
      wait_rx_ready(10, seen);
      check_event(seen, "rx_ready did not rise for a frame with a bad FCS");
      check_rx_status(64, 1'b1);
      make_frame(MAC_RESET, 80);                        // Arrives while the buffer is held
      append_fcs();
      send_rmii_frame();
      check_rx_status(64, 1'b1);
      clear_rx();
      bus_read(reg_addr(REG_RX_STAT), rd);
      check_value("rx_stat after clear", rd, 32'd0);
   endtask

   task automatic test_loopback();
      logic seen;
      bus_write(reg_addr(REG_CTRL), {5'd0, 1'b1, 10'd0, MAC_RESET[47:32]});
      make_frame(MAC_RESET, 40);
      load_tx_buffer(40);
      while (pkt.size() < 60)
         pkt.push_back(8'h00);
      append_fcs();
      bus_write(reg_addr(REG_TX), 32'd40);
      wait_rx_ready(400, seen);
      check_event(seen, "looped back frame did not reach the receive buffer");
      check_rx_status(pkt.size(), 1'b0);
      check_rx_buffer();
      clear_rx();
      wait_tx_idle();
      bus_write(reg_addr(REG_CTRL), {16'd0, MAC_RESET[47:32]});
   endtask

   initial
   begin
      errors    = 0;
      seed      = 5;
      rstn      = 1'b0;
      bus_sel   = 1'b0;
      bus_we    = 1'b0;
      bus_addr  = '0;
      bus_wdata = '0;
      rxd       = 2'b00;
      crs_dv    = 1'b0;
      repeat (3) @(posedge clk_rmii);
      rstn <= 1'b1;
      @(negedge clk_rmii);
      test_registers();
      test_transmit(20);
      test_transmit(100);
      test_unicast_receive();
      test_address_filter();
      test_bad_fcs_hold();
      test_loopback();
      $display("Run finished with %0d errors", errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial
   begin
      #(LIMIT_CYCLES * 10);
      $display("ERROR: watchdog expired after %0d cycles, tests did not finish", LIMIT_CYCLES);
      $display("Run finished with %0d errors", errors);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== src.f ====
verilog/eth_pkg.sv
verilog/frame_buffer.sv
verilog/rmii_rx.sv
verilog/eth_rx_mac.sv
verilog/eth_tx_mac.sv
verilog/eth_regs.sv
verilog/framing_top.sv
verif/tb_framing_top.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = tb_framing_top
FILELIST = src.f
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing -Wall
LOG      = sim.log
FAIL_MSG = Checks failed
PASS_MSG = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
